// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_vseq
RTL_TOP   ?= vseq_top
FILELIST  ?= sim.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "No pass status found"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/vseq_cfg.svh ====
// Vector sequencer configuration
`ifndef VSEQ_CFG_SVH
`define VSEQ_CFG_SVH

// Number of parallel vector lanes
`define VSEQ_NR_LANES 2

// Instruction IDs in flight at once
`define VSEQ_NR_VINSN 8

// Architectural vector registers
`define VSEQ_NR_VREGS 32

// Register that holds the element mask
`define VSEQ_VMASK_REG 0

// Instruction queue depth of each functional unit
`define VSEQ_ALU_DEPTH   2
`define VSEQ_MFPU_DEPTH  2
`define VSEQ_SLDU_DEPTH  1
`define VSEQ_MASKU_DEPTH 1
`define VSEQ_VLDU_DEPTH  2
`define VSEQ_VSTU_DEPTH  2

`endif

// ==== sim.f ====
+incdir+include
src/vseq_pkg.sv
src/vseq_id_alloc.sv
src/vseq_hazard_table.sv
src/vseq_queue_cnt.sv
src/vseq_issue_ctrl.sv
src/vseq_top.sv
verif/tb_clk_gen.sv
verif/tb_vseq.sv

// ==== src/vseq_hazard_table.sv ====
// Vector register hazard table
`timescale 1ns/1ps
`include "vseq_cfg.svh"

module vseq_hazard_table (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vseq_pkg::seq_req_t    req_i,
  input  vseq_pkg::vinsn_mask_t running_i,
  input  logic                  issue_i,
  input  vseq_pkg::vid_t        issue_id_i,
  output vseq_pkg::vinsn_mask_t hazard_vs1_o,
  output vseq_pkg::vinsn_mask_t hazard_vs2_o,
  output vseq_pkg::vinsn_mask_t hazard_vd_o,
  output vseq_pkg::vinsn_mask_t hazard_vm_o
);
  import vseq_pkg::*;

  // Last reader and last writer of every register
  vreg_access_t [`VSEQ_NR_VREGS-1:0] read_list_q, write_list_q;
  // Same lists with retired IDs dropped
  vreg_access_t [`VSEQ_NR_VREGS-1:0] read_live, write_live;

  // Entries looked up by the pending request
  vreg_access_t wr_vs1, wr_vs2, wr_vm, wr_vd, rd_vd;

  always_comb begin
    read_live  = read_list_q;
    write_live = write_list_q;
    for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
      read_live[v].valid  &= running_i[read_list_q[v].vid];
      write_live[v].valid &= running_i[write_list_q[v].vid];
    end
  end

  assign wr_vs1 = write_live[req_i.vs1];
  assign wr_vs2 = write_live[req_i.vs2];
  assign wr_vm  = write_live[`VSEQ_VMASK_REG];
  assign wr_vd  = write_live[req_i.vd];
  assign rd_vd  = read_live[req_i.vd];

  //////////////////////////////////////////////////////////////////////
  // Hazard masks
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;
    hazard_vm_o  = '0;

    // RAW on each source operand
    if (req_i.use_vs1 && wr_vs1.valid) hazard_vs1_o[wr_vs1.vid] = 1'b1;
    if (req_i.use_vs2 && wr_vs2.valid) hazard_vs2_o[wr_vs2.vid] = 1'b1;
    if (!req_i.vm && wr_vm.valid) hazard_vm_o[wr_vm.vid] = 1'b1;

    // WAR, the reader of vd must not be overtaken on any operand
    if (req_i.use_vd && rd_vd.valid) begin
      hazard_vs1_o[rd_vd.vid] = 1'b1;
      hazard_vs2_o[rd_vd.vid] = 1'b1;
      hazard_vm_o[rd_vd.vid]  = 1'b1;
    end

    // WAW
    if (req_i.use_vd && wr_vd.valid) hazard_vd_o[wr_vd.vid] = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // List update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_live;
      write_list_q <= write_live;
      // Issued instruction becomes the newest reader and writer
      if (issue_i) begin
        if (req_i.use_vd) write_list_q[req_i.vd] <= '{vid: issue_id_i, valid: 1'b1};
        if (req_i.use_vs1) read_list_q[req_i.vs1] <= '{vid: issue_id_i, valid: 1'b1};
        if (req_i.use_vs2) read_list_q[req_i.vs2] <= '{vid: issue_id_i, valid: 1'b1};
        if (!req_i.vm) read_list_q[`VSEQ_VMASK_REG] <= '{vid: issue_id_i, valid: 1'b1};
      end
    end
  end

endmodule

// ==== src/vseq_id_alloc.sv ====
// Instruction ID allocator
`timescale 1ns/1ps

module vseq_id_alloc (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  issue_i,
  input  vseq_pkg::vid_t        issue_id_i,
  input  vseq_pkg::seq_op_e     issue_op_i,
  input  logic                  issue_vm_i,
  input  vseq_pkg::pe_done_t    pe_done_i,
  output vseq_pkg::vinsn_mask_t running_o,
  output vseq_pkg::vinsn_mask_t running_next_o,
  output vseq_pkg::vid_t        next_id_o,
  output logic                  id_full_o,
  output logic                  idle_o
);
  import vseq_pkg::*;

  // Set bit means the ID still runs on that PE
  pe_done_t pe_running_d, pe_running_q;

  always_comb begin
    pe_running_d = pe_running_q;
    // Finished IDs leave their PE
    for (int pe = 0; pe < nr_pes; pe++) begin
      pe_running_d[pe] &= ~pe_done_i[pe];
    end
    if (issue_i) begin
      case (vseq_home_vfu(issue_op_i))
        VFU_LOAD:  pe_running_d[pe_load][issue_id_i] = 1'b1;
        VFU_STORE: pe_running_d[pe_store][issue_id_i] = 1'b1;
        VFU_SLIDE: pe_running_d[pe_slide][issue_id_i] = 1'b1;
        VFU_MASK:  pe_running_d[pe_mask][issue_id_i] = 1'b1;
        default: begin
          // ALU and MFPU work spreads over all lanes
          for (int l = 0; l < nr_lanes; l++) begin
            pe_running_d[l][issue_id_i] = 1'b1;
          end
        end
      endcase
      // Masked instructions also go through the mask unit
      if (!issue_vm_i) pe_running_d[pe_mask][issue_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_running_q <= '0;
    end else begin
      pe_running_q <= pe_running_d;
    end
  end

  // An ID runs while any PE holds it
  always_comb begin
    running_o      = '0;
    running_next_o = '0;
    for (int pe = 0; pe < nr_pes; pe++) begin
      running_o      |= pe_running_q[pe];
      running_next_o |= pe_running_d[pe];
    end
  end

  // Lowest free ID, scanned from the top so the last hit wins
  always_comb begin
    next_id_o = '0;
    for (int i = $bits(vinsn_mask_t) - 1; i >= 0; i--) begin
      if (!running_o[i]) next_id_o = vid_t'(i);
    end
  end

  assign id_full_o = &running_o;
  assign idle_o    = ~|running_o;

endmodule

// ==== src/vseq_issue_ctrl.sv ====
// Sequencer issue control
`timescale 1ns/1ps

module vseq_issue_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vseq_pkg::seq_req_t    req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output vseq_pkg::seq_resp_t   resp_o,
  output logic                  resp_valid_o,
  input  vseq_pkg::vid_t        next_id_i,
  input  logic                  id_full_i,
  input  vseq_pkg::vinsn_mask_t running_next_i,
  input  vseq_pkg::vinsn_mask_t hazard_vs1_i,
  input  vseq_pkg::vinsn_mask_t hazard_vs2_i,
  input  vseq_pkg::vinsn_mask_t hazard_vd_i,
  input  vseq_pkg::vinsn_mask_t hazard_vm_i,
  input  logic                  units_ready_i,
  output logic                  issue_o,
  output vseq_pkg::vfu_mask_t   targets_o,
  output vseq_pkg::pe_req_t     pe_req_o,
  output logic                  pe_req_valid_o,
  input  logic                  pe_req_ready_i,
  input  logic [31:0]           scalar_resp_i,
  input  logic                  scalar_valid_i,
  input  logic                  addrgen_ack_i,
  input  logic                  addrgen_error_i
);
  import vseq_pkg::*;

  // WAIT holds the dispatcher until a load, store or scalar answer
  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e  state_d, state_q;
  pe_req_t pe_req_d, pe_req_held;
  logic    pe_req_valid_d;
  logic    pe_stuck;
  logic    no_operands;
  logic    hazard_stall;
  logic    wait_done;
  logic    open_slot;

  assign targets_o = vseq_target_vfus(req_i.op);

  // Lane 0 has not taken the request yet
  assign pe_stuck = pe_req_valid_o && !pe_req_ready_i;

  // Held request forgets producers that have finished
  always_comb begin
    pe_req_held = pe_req_o;
    pe_req_held.hazard_vs1 &= running_next_i;
    pe_req_held.hazard_vs2 &= running_next_i;
    pe_req_held.hazard_vd  &= running_next_i;
    pe_req_held.hazard_vm  &= running_next_i;
  end

  // Without operands there is nothing to chain on
  assign no_operands  = !req_i.use_vs1 && !req_i.use_vs2 && req_i.vm;
  assign hazard_stall = (no_operands && |{hazard_vs1_i, hazard_vs2_i, hazard_vd_i, hazard_vm_i})
                     || (req_i.op == VSLIDEUP && |{hazard_vd_i, hazard_vs1_i, hazard_vs2_i});

  //////////////////////////////////////////////////////////////////////
  // Dispatcher response
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wait_done = 1'b0;
    resp_o    = '0;
    if (state_q == WAIT) begin
      // Memory ops finish at address translation
      if ((pe_req_o.op == VLE || pe_req_o.op == VSE) && addrgen_ack_i) begin
        wait_done    = 1'b1;
        resp_o.error = addrgen_error_i;
      end
      // Scalar move returns through the slide unit
      if (pe_req_o.op == VMV_X_S && scalar_valid_i) begin
        wait_done   = 1'b1;
        resp_o.resp = scalar_resp_i;
      end
    end
  end

  assign resp_valid_o = wait_done;

  // The slot reopens in the cycle that closes WAIT
  assign open_slot = (state_q == IDLE) || wait_done;

  //////////////////////////////////////////////////////////////////////
  // Accept and issue
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = wait_done ? IDLE : state_q;
    pe_req_d       = pe_req_held;
    pe_req_valid_d = pe_stuck;
    issue_o        = 1'b0;
    req_ready_o    = 1'b0;
    if (open_slot && !pe_stuck) begin
      req_ready_o = 1'b1;
      if (req_valid_i) begin
        if (units_ready_i && !id_full_i && !hazard_stall) begin
          issue_o        = 1'b1;
          pe_req_valid_d = 1'b1;
          pe_req_d       = '{
            id:         next_id_i,
            op:         req_i.op,
            vfu:        vseq_home_vfu(req_i.op),
            vs1:        req_i.vs1,
            use_vs1:    req_i.use_vs1,
            vs2:        req_i.vs2,
            use_vs2:    req_i.use_vs2,
            vd:         req_i.vd,
            use_vd:     req_i.use_vd,
            vm:         req_i.vm,
            hazard_vs1: hazard_vs1_i,
            hazard_vs2: hazard_vs2_i,
            hazard_vd:  hazard_vd_i,
            hazard_vm:  hazard_vm_i
          };
          if (req_i.op inside {VLE, VSE, VMV_X_S}) state_d = WAIT;
        end else begin
          // Stalled on a queue, on IDs or on a hazard
          req_ready_o = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    pe_req_o <= pe_req_d;
  end

endmodule

// ==== src/vseq_pkg.sv ====
// Vector sequencer types
`include "vseq_cfg.svh"

package vseq_pkg;

  // PE order is lanes first, then load, store, slide and mask units
  localparam int unsigned nr_lanes = `VSEQ_NR_LANES;
  localparam int unsigned nr_pes   = nr_lanes + 4;
  localparam int unsigned pe_load  = nr_lanes;
  localparam int unsigned pe_store = nr_lanes + 1;
  localparam int unsigned pe_slide = nr_lanes + 2;
  localparam int unsigned pe_mask  = nr_lanes + 3;
  localparam int unsigned nr_vfus  = 6;

  typedef logic [$clog2(`VSEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [`VSEQ_NR_VINSN-1:0]         vinsn_mask_t;
  typedef logic [$clog2(`VSEQ_NR_VREGS)-1:0] vreg_t;

  // Functional units, also the bit order of vfu_mask_t
  typedef enum logic [2:0] {
    VFU_ALU,
    VFU_MFPU,
    VFU_SLIDE,
    VFU_MASK,
    VFU_LOAD,
    VFU_STORE
  } vfu_e;

  typedef logic [nr_vfus-1:0] vfu_mask_t;

  typedef enum logic [2:0] {
    VADD,
    VMUL,
    VMSEQ,
    VLE,
    VSE,
    VSLIDEUP,
    VMV_X_S
  } seq_op_e;

  // Request from the dispatcher, vm set means unmasked
  typedef struct packed {
    seq_op_e op;
    vreg_t   vs1;
    logic    use_vs1;
    vreg_t   vs2;
    logic    use_vs2;
    vreg_t   vd;
    logic    use_vd;
    logic    vm;
  } seq_req_t;

  typedef struct packed {
    logic [31:0] resp;
    logic        error;
  } seq_resp_t;

  // Request broadcast to every PE
  typedef struct packed {
    vid_t        id;
    seq_op_e     op;
    vfu_e        vfu;
    vreg_t       vs1;
    logic        use_vs1;
    vreg_t       vs2;
    logic        use_vs2;
    vreg_t       vd;
    logic        use_vd;
    logic        vm;
    vinsn_mask_t hazard_vs1;
    vinsn_mask_t hazard_vs2;
    vinsn_mask_t hazard_vd;
    vinsn_mask_t hazard_vm;
  } pe_req_t;

  // One done mask per PE
  typedef logic [nr_pes-1:0][`VSEQ_NR_VINSN-1:0] pe_done_t;

  // Last reader or writer of a vector register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  // Unit that owns the instruction
  function automatic vfu_e vseq_home_vfu(seq_op_e op);
    case (op)
      VMUL:     return VFU_MFPU;
      VMSEQ:    return VFU_MASK;
      VLE:      return VFU_LOAD;
      VSE:      return VFU_STORE;
      VSLIDEUP: return VFU_SLIDE;
      VMV_X_S:  return VFU_SLIDE;
      default:  return VFU_ALU;
    endcase
  endfunction

  // Every unit whose queue the instruction occupies
  function automatic vfu_mask_t vseq_target_vfus(seq_op_e op);
    vfu_mask_t targets;
    targets                    = '0;
    targets[vseq_home_vfu(op)] = 1'b1;
    // Compares run on the ALU and finish in the mask unit
    if (op == VMSEQ) targets[VFU_ALU] = 1'b1;
    return targets;
  endfunction

endpackage

// ==== src/vseq_queue_cnt.sv ====
// Functional unit queue counters
`timescale 1ns/1ps
`include "vseq_cfg.svh"

module vseq_queue_cnt (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vseq_pkg::vfu_mask_t targets_i,
  input  logic                accept_i,
  input  vseq_pkg::pe_done_t  pe_done_i,
  input  logic                alu_done_i,
  input  logic                mfpu_done_i,
  output logic                units_ready_o
);
  import vseq_pkg::*;

  // Depth per unit, in vfu_e order
  localparam int unsigned depth [nr_vfus] = '{
    `VSEQ_ALU_DEPTH,
    `VSEQ_MFPU_DEPTH,
    `VSEQ_SLDU_DEPTH,
    `VSEQ_MASKU_DEPTH,
    `VSEQ_VLDU_DEPTH,
    `VSEQ_VSTU_DEPTH
  };

  // A unit never holds more instructions than there are IDs
  localparam int unsigned cnt_w = $clog2(`VSEQ_NR_VINSN + 1);

  vfu_mask_t unit_done;
  vfu_mask_t unit_ok;

  // Lanes report ALU and MFPU completion on their own lines
  assign unit_done[VFU_ALU]   = alu_done_i;
  assign unit_done[VFU_MFPU]  = mfpu_done_i;
  assign unit_done[VFU_SLIDE] = |pe_done_i[pe_slide];
  assign unit_done[VFU_MASK]  = |pe_done_i[pe_mask];
  assign unit_done[VFU_LOAD]  = |pe_done_i[pe_load];
  assign unit_done[VFU_STORE] = |pe_done_i[pe_store];

  for (genvar i = 0; i < nr_vfus; i++) begin : gen_cnt
    logic [cnt_w-1:0] cnt_q;
    logic             cnt_up;

    assign cnt_up = accept_i & targets_i[i];

    // Up and down in one cycle cancel out
    // Mask PE also finishes masked work that never took a mask queue slot
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !unit_done[i]) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (unit_done[i] && !cnt_up && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // Units outside the target set never block
    assign unit_ok[i] = !targets_i[i] || (cnt_q < cnt_w'(depth[i]));
  end

  assign units_ready_o = &unit_ok;

endmodule

// ==== src/vseq_top.sv ====
// Vector instruction sequencer
`timescale 1ns/1ps

module vseq_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Dispatcher side
  input  vseq_pkg::seq_req_t    req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output vseq_pkg::seq_resp_t   resp_o,
  output logic                  resp_valid_o,
  output logic                  idle_o,
  // PE side
  output vseq_pkg::pe_req_t     pe_req_o,
  output logic                  pe_req_valid_o,
  input  logic                  pe_req_ready_i,
  output vseq_pkg::vinsn_mask_t pe_vinsn_running_o,
  input  vseq_pkg::pe_done_t    pe_done_i,
  input  logic                  alu_done_i,
  input  logic                  mfpu_done_i,
  input  logic [31:0]           scalar_resp_i,
  input  logic                  scalar_valid_i,
  input  logic                  addrgen_ack_i,
  input  logic                  addrgen_error_i
);
  import vseq_pkg::*;

  vinsn_mask_t running;
  vinsn_mask_t running_next;
  vid_t        next_id;
  logic        id_full;
  vinsn_mask_t hazard_vs1, hazard_vs2, hazard_vd, hazard_vm;
  logic        units_ready;
  logic        issue;
  vfu_mask_t   targets;

  assign pe_vinsn_running_o = running;

  // Issued ID is always the lowest free one
  vseq_id_alloc id_alloc_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (issue),
    .issue_id_i     (next_id),
    .issue_op_i     (req_i.op),
    .issue_vm_i     (req_i.vm),
    .pe_done_i      (pe_done_i),
    .running_o      (running),
    .running_next_o (running_next),
    .next_id_o      (next_id),
    .id_full_o      (id_full),
    .idle_o         (idle_o)
  );

  vseq_hazard_table hazard_table_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .running_i    (running),
    .issue_i      (issue),
    .issue_id_i   (next_id),
    .hazard_vs1_o (hazard_vs1),
    .hazard_vs2_o (hazard_vs2),
    .hazard_vd_o  (hazard_vd),
    .hazard_vm_o  (hazard_vm)
  );

  vseq_queue_cnt queue_cnt_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .targets_i     (targets),
    .accept_i      (issue),
    .pe_done_i     (pe_done_i),
    .alu_done_i    (alu_done_i),
    .mfpu_done_i   (mfpu_done_i),
    .units_ready_o (units_ready)
  );

  vseq_issue_ctrl issue_ctrl_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .resp_o          (resp_o),
    .resp_valid_o    (resp_valid_o),
    .next_id_i       (next_id),
    .id_full_i       (id_full),
    .running_next_i  (running_next),
    .hazard_vs1_i    (hazard_vs1),
    .hazard_vs2_i    (hazard_vs2),
    .hazard_vd_i     (hazard_vd),
    .hazard_vm_i     (hazard_vm),
    .units_ready_i   (units_ready),
    .issue_o         (issue),
    .targets_o       (targets),
    .pe_req_o        (pe_req_o),
    .pe_req_valid_o  (pe_req_valid_o),
    .pe_req_ready_i  (pe_req_ready_i),
    .scalar_resp_i   (scalar_resp_i),
    .scalar_valid_i  (scalar_valid_i),
    .addrgen_ack_i   (addrgen_ack_i),
    .addrgen_error_i (addrgen_error_i)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset held low for 5 cycles, released just after an edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

// ==== verif/tb_vseq.sv ====
// Vector sequencer testbench
`timescale 1ns/1ps
`include "vseq_cfg.svh"

module tb_vseq;
  import vseq_pkg::*;

  localparam int unsigned max_cycles = 2000;

  logic        clk_i, rst_ni;
  seq_req_t    req_i;
  logic        req_valid_i, req_ready_o, resp_valid_o, idle_o;
  seq_resp_t   resp_o;
  pe_req_t     pe_req_o;
  logic        pe_req_valid_o, pe_req_ready_i;
  vinsn_mask_t pe_vinsn_running_o;
  pe_done_t    pe_done_i;
  logic        alu_done_i, mfpu_done_i, scalar_valid_i;
  logic        addrgen_ack_i, addrgen_error_i;
  logic [31:0] scalar_resp_i;

  // Shadow state
  pe_done_t     sh_run;
  vreg_access_t sh_wr [`VSEQ_NR_VREGS];
  vreg_access_t sh_rd [`VSEQ_NR_VREGS];
  seq_op_e      id_op [`VSEQ_NR_VINSN];
  logic         id_vm [`VSEQ_NR_VINSN];
  int unsigned  lcg_state = 68285;
  int unsigned  cycle_cnt = 0;
  int unsigned  fail_count = 0;

  tb_clk_gen clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

  vseq_top dut_i (.*);

  function automatic int unsigned lcg_next();
    lcg_state = (lcg_state * 1103515245 + 12345) & 32'h7fffffff;
    return lcg_state >> 8;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      fail_count++;
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  // PEs that run an op, from the unit table
  function automatic logic [nr_pes-1:0] pes_for(seq_op_e op, logic vm);
    logic [nr_pes-1:0] p;
    p = '0;
    case (op)
      VADD, VMUL: p[1:0] = 2'b11;
      VLE:        p[pe_load] = 1'b1;
      VSE:        p[pe_store] = 1'b1;
      VMSEQ:      p[pe_mask] = 1'b1;
      default:    p[pe_slide] = 1'b1;
    endcase
    if (!vm) p[pe_mask] = 1'b1;
    return p;
  endfunction

  function automatic vfu_e exp_home(seq_op_e op);
    case (op)
      VADD:    return VFU_ALU;
      VMUL:    return VFU_MFPU;
      VMSEQ:   return VFU_MASK;
      VLE:     return VFU_LOAD;
      VSE:     return VFU_STORE;
      default: return VFU_SLIDE;
    endcase
  endfunction

  function automatic vinsn_mask_t shadow_running();
    vinsn_mask_t m;
    m = '0;
    for (int pe = 0; pe < nr_pes; pe++) m |= sh_run[pe];
    return m;
  endfunction

  function automatic vid_t lowest_free();
    vinsn_mask_t m;
    m = shadow_running();
    for (int i = 0; i < `VSEQ_NR_VINSN; i++) begin
      if (!m[i]) return vid_t'(i);
    end
    return '0;
  endfunction

  // RAW, WAR and WAW from the shadow lists
  task automatic exp_hazards(input seq_req_t r, output vinsn_mask_t h1, output vinsn_mask_t h2,
                             output vinsn_mask_t hd, output vinsn_mask_t hm);
    h1 = '0;
    h2 = '0;
    hd = '0;
    hm = '0;
    if (r.use_vs1 && sh_wr[r.vs1].valid) h1[sh_wr[r.vs1].vid] = 1'b1;
    if (r.use_vs2 && sh_wr[r.vs2].valid) h2[sh_wr[r.vs2].vid] = 1'b1;
    if (!r.vm && sh_wr[`VSEQ_VMASK_REG].valid) hm[sh_wr[`VSEQ_VMASK_REG].vid] = 1'b1;
    if (r.use_vd && sh_rd[r.vd].valid) begin
      h1[sh_rd[r.vd].vid] = 1'b1;
      h2[sh_rd[r.vd].vid] = 1'b1;
      hm[sh_rd[r.vd].vid] = 1'b1;
    end
    if (r.use_vd && sh_wr[r.vd].valid) hd[sh_wr[r.vd].vid] = 1'b1;
  endtask

  function automatic seq_req_t mk_req(seq_op_e op, int vd, int vs1, int vs2, logic vm);
    seq_req_t r;
    r         = '0;
    r.op      = op;
    r.vd      = vreg_t'(vd < 0 ? 0 : vd);
    r.use_vd  = vd >= 0;
    r.vs1     = vreg_t'(vs1 < 0 ? 0 : vs1);
    r.use_vs1 = vs1 >= 0;
    r.vs2     = vreg_t'(vs2 < 0 ? 0 : vs2);
    r.use_vs2 = vs2 >= 0;
    r.vm      = vm;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Dispatcher and PE driving
  //////////////////////////////////////////////////////////////////////

  task automatic send(input seq_req_t r, input bit hold_ready, output pe_req_t got);
    vid_t              exp_id;
    vinsn_mask_t       h1, h2, hd, hm;
    logic [nr_pes-1:0] p;
    int unsigned       gap;
    logic [31:0]       sval;
    logic              aerr;
    req_i       = r;
    req_valid_i = 1'b1;
    #1;
    while (!req_ready_o) begin
      step();
      #1;
    end
    exp_id = lowest_free();
    exp_hazards(r, h1, h2, hd, hm);
    step();
    req_valid_i = 1'b0;
    // Shadow records the issue
    p = pes_for(r.op, r.vm);
    for (int pe = 0; pe < nr_pes; pe++) begin
      if (p[pe]) sh_run[pe][exp_id] = 1'b1;
    end
    id_op[exp_id] = r.op;
    id_vm[exp_id] = r.vm;
    if (r.use_vd) sh_wr[r.vd] = '{vid: exp_id, valid: 1'b1};
    if (r.use_vs1) sh_rd[r.vs1] = '{vid: exp_id, valid: 1'b1};
    if (r.use_vs2) sh_rd[r.vs2] = '{vid: exp_id, valid: 1'b1};
    if (!r.vm) sh_rd[`VSEQ_VMASK_REG] = '{vid: exp_id, valid: 1'b1};
    #1;
    got = pe_req_o;
    check("issue_valid", 1, pe_req_valid_o);
    check("issue_id", exp_id, pe_req_o.id);
    check("issue_op", r.op, pe_req_o.op);
    check("issue_vfu", exp_home(r.op), pe_req_o.vfu);
    check("issue_vd", r.vd, pe_req_o.vd);
    check("issue_vs1", r.vs1, pe_req_o.vs1);
    check("issue_vs2", r.vs2, pe_req_o.vs2);
    check("issue_flags", {r.use_vs1, r.use_vs2, r.use_vd, r.vm},
          {pe_req_o.use_vs1, pe_req_o.use_vs2, pe_req_o.use_vd, pe_req_o.vm});
    check("hazard_vs1", h1, pe_req_o.hazard_vs1);
    check("hazard_vs2", h2, pe_req_o.hazard_vs2);
    check("hazard_vd", hd, pe_req_o.hazard_vd);
    check("hazard_vm", hm, pe_req_o.hazard_vm);
    check("running", shadow_running(), pe_vinsn_running_o);
    check("not_idle", 0, idle_o);
    if (hold_ready) begin
      pe_req_ready_i = 1'b0;
      return;
    end
    // Random back-pressure from lane 0
    gap = lcg_next() % 3;
    if (gap != 0) pe_req_ready_i = 1'b0;
    repeat (gap) begin
      step();
      #1;
      check("stuck_valid", 1, pe_req_valid_o);
      check("stuck_ready", 0, req_ready_o);
    end
    pe_req_ready_i = 1'b1;
    step();
    #1;
    check("taken_valid", 0, pe_req_valid_o);
    if (r.op inside {VLE, VSE, VMV_X_S}) begin
      repeat (lcg_next() % 3) begin
        check("wait_ready", 0, req_ready_o);
        step();
        #1;
      end
      check("wait_ready", 0, req_ready_o);
      sval = lcg_next();
      aerr = sval[3];
      if (r.op == VMV_X_S) begin
        scalar_resp_i  = sval;
        scalar_valid_i = 1'b1;
      end else begin
        addrgen_error_i = aerr;
        addrgen_ack_i   = 1'b1;
      end
      #1;
      check("resp_valid", 1, resp_valid_o);
      check("resp_ready", 1, req_ready_o);
      check("resp_data", r.op == VMV_X_S ? sval : 32'h0, resp_o.resp);
      check("resp_error", r.op == VMV_X_S ? 1'b0 : aerr, resp_o.error);
      step();
      scalar_valid_i = 1'b0;
      addrgen_ack_i  = 1'b0;
      #1;
      check("resp_closed", 0, resp_valid_o);
    end
  endtask

  // Done pulse on every PE and unit counter the ID occupies
  task automatic retire(input vid_t id);
    logic [nr_pes-1:0] p;
    vinsn_mask_t       m;
    p = pes_for(id_op[id], id_vm[id]);
    for (int pe = 0; pe < nr_pes; pe++) begin
      if (p[pe]) pe_done_i[pe][id] = 1'b1;
    end
    alu_done_i  = id_op[id] inside {VADD, VMSEQ};
    mfpu_done_i = id_op[id] == VMUL;
    step();
    pe_done_i   = '0;
    alu_done_i  = 1'b0;
    mfpu_done_i = 1'b0;
    for (int pe = 0; pe < nr_pes; pe++) sh_run[pe][id] = 1'b0;
    // Lists forget retired IDs
    m = shadow_running();
    for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
      if (sh_wr[v].valid && !m[sh_wr[v].vid]) sh_wr[v].valid = 1'b0;
      if (sh_rd[v].valid && !m[sh_rd[v].vid]) sh_rd[v].valid = 1'b0;
    end
    #1;
    check("running_after_done", m, pe_vinsn_running_o);
  endtask

  task automatic retire_all();
    vinsn_mask_t m;
    m = shadow_running();
    for (int i = 0; i < `VSEQ_NR_VINSN; i++) begin
      if (m[i]) retire(vid_t'(i));
    end
    check("idle_again", 1, idle_o);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Assertions on the held PE request
  //////////////////////////////////////////////////////////////////////

  hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pe_req_valid_o && !pe_req_ready_i) |=> (pe_req_valid_o && $stable(pe_req_o.id)
      && $stable(pe_req_o.op) && $stable(pe_req_o.vd)))
    else begin
      fail_count++;
      $display("Held PE request changed or dropped under back-pressure");
      $display("STATUS: FAIL");
      $fatal(1);
    end

  hold_trim: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pe_req_valid_o && !pe_req_ready_i) |=>
      (((pe_req_o.hazard_vs1 | pe_req_o.hazard_vs2 | pe_req_o.hazard_vd
         | pe_req_o.hazard_vm) & ~pe_vinsn_running_o) == '0))
    else begin
      fail_count++;
      $display("Held PE request kept a hazard on a finished ID");
      $display("STATUS: FAIL");
      $fatal(1);
    end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout after %0d cycles with tests still running", max_cycles);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    pe_req_t  got;
    seq_req_t r;
    req_i           = '0;
    req_valid_i     = 1'b0;
    pe_req_ready_i  = 1'b1;
    pe_done_i       = '0;
    alu_done_i      = 1'b0;
    mfpu_done_i     = 1'b0;
    scalar_resp_i   = '0;
    scalar_valid_i  = 1'b0;
    addrgen_ack_i   = 1'b0;
    addrgen_error_i = 1'b0;
    sh_run          = '0;
    for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
      sh_wr[v] = '0;
      sh_rd[v] = '0;
    end
    @(posedge rst_ni);
    step();
    #1;
    check("reset_idle", 1, idle_o);
    check("reset_pe_valid", 0, pe_req_valid_o);
    check("reset_resp_valid", 0, resp_valid_o);
    check("reset_ready", 1, req_ready_o);

    // Single add then idle
    send(mk_req(VADD, 1, 2, 3, 1'b1), 1'b0, got);
    check("first_id", 0, got.id);
    check("first_vfu", VFU_ALU, got.vfu);
    retire(0);
    check("idle_after_done", 1, idle_o);

    // RAW, WAW and WAR
    send(mk_req(VADD, 3, 4, 5, 1'b1), 1'b0, got);
    send(mk_req(VMUL, 6, 3, 7, 1'b1), 1'b0, got);
    check("raw_vs1", 8'h01, got.hazard_vs1);
    send(mk_req(VADD, 3, 8, 9, 1'b1), 1'b0, got);
    check("waw_vd", 8'h01, got.hazard_vd);
    retire(2);
    send(mk_req(VADD, 7, 10, 11, 1'b1), 1'b0, got);
    check("war_vs2", 8'h02, got.hazard_vs2);
    check("war_vm", 8'h02, got.hazard_vm);
    retire_all();

    // Held request loses its hazard once the producer finishes
    send(mk_req(VADD, 12, 13, 14, 1'b1), 1'b0, got);
    send(mk_req(VMUL, 15, 12, 16, 1'b1), 1'b1, got);
    check("held_raw", 8'h01, got.hazard_vs1);
    repeat (3) step();
    #1;
    check("held_ready_low", 0, req_ready_o);
    retire(0);
    check("held_trimmed", 0, pe_req_o.hazard_vs1);
    check("held_still_valid", 1, pe_req_valid_o);
    pe_req_ready_i = 1'b1;
    step();
    #1;
    check("held_taken", 0, pe_req_valid_o);
    retire_all();

    // Fill every ID, the waiting slide has a free queue slot
    send(mk_req(VADD, 16, 17, 18, 1'b1), 1'b0, got);
    send(mk_req(VADD, 19, 20, 21, 1'b1), 1'b0, got);
    send(mk_req(VMUL, 22, 23, 24, 1'b1), 1'b0, got);
    send(mk_req(VMUL, 25, 26, 27, 1'b1), 1'b0, got);
    send(mk_req(VLE, 28, -1, -1, 1'b1), 1'b0, got);
    send(mk_req(VLE, 29, -1, -1, 1'b1), 1'b0, got);
    send(mk_req(VSE, -1, 30, -1, 1'b1), 1'b0, got);
    send(mk_req(VSE, -1, 31, -1, 1'b1), 1'b0, got);
    check("all_running", 8'hff, pe_vinsn_running_o);
    r           = mk_req(VSLIDEUP, 1, 2, 3, 1'b1);
    req_i       = r;
    req_valid_i = 1'b1;
    repeat (4) begin
      #1;
      check("full_ready", 0, req_ready_o);
      step();
    end
    retire(1);
    send(r, 1'b0, got);
    check("reused_id", 1, got.id);
    retire_all();

    // Load into the mask register, scalar move and a masked add
    send(mk_req(VLE, 0, -1, -1, 1'b1), 1'b0, got);
    send(mk_req(VMV_X_S, -1, -1, 6, 1'b1), 1'b0, got);
    send(mk_req(VADD, 26, 27, 28, 1'b0), 1'b0, got);
    check("masked_vm", 8'h01, got.hazard_vm);
    retire_all();

    // Mask unit depth of one
    send(mk_req(VMSEQ, 20, 21, 22, 1'b1), 1'b0, got);
    r           = mk_req(VMSEQ, 23, 24, 25, 1'b1);
    req_i       = r;
    req_valid_i = 1'b1;
    repeat (4) begin
      #1;
      check("queue_ready", 0, req_ready_o);
      step();
    end
    retire(0);
    send(r, 1'b0, got);
    check("queue_id", 0, got.id);
    retire_all();

    if (fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
